// ==== compile.f ====
hdl/cpuPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/hazardUnit.sv
hdl/cpuTop.sv
tests/cpuTb.sv

// ==== hdl/cpuPkg.sv ====
package cpuPkg;

  // ********************************************************************
  // Instruction encoding
  // ********************************************************************

  typedef enum logic [3:0] {
    opAdd = 4'h0,
    opSub = 4'h1,
    opAnd = 4'h2,
    opNor = 4'h3,
    opLw  = 4'h8,
    opSw  = 4'h9,
    opLlb = 4'hA,
    opB   = 4'hC,
    opHlt = 4'hF
  } opcodeT;

  // Branch conditions on the Z, N and V flags
  typedef enum logic [2:0] {
    condNe     = 3'd0,
    condEq     = 3'd1,
    condGt     = 3'd2,
    condLt     = 3'd3,
    condGe     = 3'd4,
    condLe     = 3'd5,
    condOv     = 3'd6,
    condAlways = 3'd7
  } condT;

  typedef struct packed {
    opcodeT     opcode;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } rFmtT;

  typedef struct packed {
    opcodeT     opcode;
    logic [3:0] rd;
    logic [7:0] imm8;
  } iFmtT;

  // Memory ops use rt as load destination or store source
  typedef struct packed {
    opcodeT     opcode;
    logic [3:0] rt;
    logic [3:0] rs;
    logic [3:0] off4;
  } mFmtT;

  typedef struct packed {
    opcodeT     opcode;
    condT       cond3;
    logic [8:0] off9;
  } bFmtT;

  typedef union packed {
    rFmtT rFmt;
    iFmtT iFmt;
    mFmtT mFmt;
    bFmtT bFmt;
  } instrU;

  // ********************************************************************
  // Pipeline registers
  // ********************************************************************

  typedef struct packed {
    logic [15:0] instr;
    logic [15:0] pcPlus1;
    logic        valid;
  } ifIdT;

  typedef struct packed {
    logic [15:0] opA;
    logic [15:0] opB;
    logic [3:0]  srcA;
    logic [3:0]  srcB;
    logic [3:0]  dst;
    logic [15:0] imm;
    opcodeT      aluOp;
    logic        regWe;
    logic        memRe;
    logic        memWe;
    logic        isBranch;
    logic        isHalt;
    logic        setsAllFlags;
    logic        setsZero;
    condT        cond;
    logic [15:0] pcPlus1;
    logic        valid;
  } idExT;

  typedef struct packed {
    logic [15:0] result;
    logic [15:0] storeData;
    logic [3:0]  storeSrc;
    logic [3:0]  dst;
    logic        regWe;
    logic        memRe;
    logic        memWe;
    logic        isHalt;
    logic        valid;
  } exMemT;

  typedef struct packed {
    logic [15:0] data;
    logic [3:0]  dst;
    logic        regWe;
    logic        isHalt;
  } memWbT;

  typedef struct packed {
    logic [3:0]  regNum;
    logic [15:0] value;
  } retireT;

endpackage

// ==== hdl/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop #(
  parameter int imemDepth = 256,
  parameter int dmemDepth = 256
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           go,
  input  logic           loadReq,
  input  logic [15:0]    loadAddr,
  input  logic [15:0]    loadInstr,
  output logic           loadAck,
  output logic           hlt,
  output logic [15:0]    pc,
  output logic           retireValid,
  output cpuPkg::retireT retire
);

  cpuPkg::ifIdT  ifId;
  cpuPkg::idExT  idEx;
  cpuPkg::exMemT exMem;
  cpuPkg::memWbT memWb;

  logic        stall;
  logic        flush;
  logic        halted;
  logic        branchTaken;
  logic [15:0] branchTarget;
  logic [3:0]  idSrcA;
  logic [3:0]  idSrcB;

  fetchStage #(
    .imemDepth(imemDepth)
  ) u_fetch (
    .clk(clk), .rst_n(rst_n), .go(go),
    .stall(stall), .flush(flush), .halted(halted),
    .branchTaken(branchTaken), .branchTarget(branchTarget),
    .loadReq(loadReq), .loadAddr(loadAddr), .loadInstr(loadInstr),
    .loadAck(loadAck), .pc(pc), .ifId(ifId)
  );

  decodeStage u_decode (
    .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
    .ifId(ifId), .wb(memWb),
    .idEx(idEx), .idSrcA(idSrcA), .idSrcB(idSrcB)
  );

  executeStage u_execute (
    .clk(clk), .rst_n(rst_n), .idEx(idEx),
    .exMemFwd(exMem), .wbFwd(memWb),
    .exMem(exMem), .branchTaken(branchTaken), .branchTarget(branchTarget)
  );

  memoryStage #(
    .dmemDepth(dmemDepth)
  ) u_memory (
    .clk(clk), .rst_n(rst_n), .exMem(exMem), .memWb(memWb)
  );

  // HLT entering WB
  hazardUnit u_hazard (
    .clk(clk), .rst_n(rst_n), .idEx(idEx),
    .idSrcA(idSrcA), .idSrcB(idSrcB),
    .branchTaken(branchTaken), .hlt(memWb.isHalt),
    .stall(stall), .flush(flush), .halted(halted)
  );

  assign hlt          = halted;
  assign retire.regNum = memWb.dst;
  assign retire.value  = memWb.data;
  assign retireValid  = memWb.regWe && (memWb.dst != 4'd0);

endmodule

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          stall,
  input  logic          flush,
  input  cpuPkg::ifIdT  ifId,
  input  cpuPkg::memWbT wb,
  output cpuPkg::idExT  idEx,
  output logic [3:0]    idSrcA,
  output logic [3:0]    idSrcB
);

  logic [15:0]   regFile [16];
  cpuPkg::instrU word;
  cpuPkg::idExT  dec;
  cpuPkg::idExT  idExNext;
  logic          live;

  // Reads see the value being written back this cycle
  function automatic logic [15:0] readReg(input logic [3:0] addr);
    if (addr == 4'd0) begin
      return 16'd0;
    end else if (wb.regWe && wb.dst == addr) begin
      return wb.data;
    end
    return regFile[addr];
  endfunction

  assign word = ifId.instr;
  assign live = ifId.valid && !stall && !flush;

  // ********************************************************************
  // Field decode
  // ********************************************************************
  always_comb begin
    dec         = '0;
    dec.aluOp   = word.rFmt.opcode;
    dec.cond    = word.bFmt.cond3;
    dec.pcPlus1 = ifId.pcPlus1;
    case (word.rFmt.opcode)
      cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opNor: begin
        dec.srcA         = word.rFmt.rs;
        dec.srcB         = word.rFmt.rt;
        dec.dst          = word.rFmt.rd;
        dec.regWe        = 1'b1;
        dec.setsAllFlags = word.rFmt.opcode inside {cpuPkg::opAdd, cpuPkg::opSub};
        dec.setsZero     = word.rFmt.opcode inside {cpuPkg::opAnd, cpuPkg::opNor};
      end
      cpuPkg::opLlb: begin
        dec.dst   = word.iFmt.rd;
        dec.imm   = {{8{word.iFmt.imm8[7]}}, word.iFmt.imm8};
        dec.regWe = 1'b1;
      end
      cpuPkg::opLw: begin
        dec.srcA  = word.mFmt.rs;
        dec.dst   = word.mFmt.rt;
        dec.imm   = {{12{word.mFmt.off4[3]}}, word.mFmt.off4};
        dec.regWe = 1'b1;
        dec.memRe = 1'b1;
      end
      cpuPkg::opSw: begin
        dec.srcA  = word.mFmt.rs;
        dec.srcB  = word.mFmt.rt;
        dec.imm   = {{12{word.mFmt.off4[3]}}, word.mFmt.off4};
        dec.memWe = 1'b1;
      end
      cpuPkg::opB: begin
        dec.imm      = {{7{word.bFmt.off9[8]}}, word.bFmt.off9};
        dec.isBranch = 1'b1;
      end
      cpuPkg::opHlt: dec.isHalt = 1'b1;
      default: ;
    endcase
    // r0 is hardwired, so writes to it are dropped here
    if (dec.dst == 4'd0) begin
      dec.regWe = 1'b0;
    end
  end

  assign idSrcA = ifId.valid ? dec.srcA : 4'd0;
  assign idSrcB = ifId.valid ? dec.srcB : 4'd0;

  // Bubble on stall, flush or empty slot
  always_comb begin
    idExNext       = dec;
    idExNext.opA   = readReg(dec.srcA);
    idExNext.opB   = readReg(dec.srcB);
    idExNext.valid = live;
    if (!live) begin
      idExNext.regWe        = 1'b0;
      idExNext.memRe        = 1'b0;
      idExNext.memWe        = 1'b0;
      idExNext.isBranch     = 1'b0;
      idExNext.isHalt       = 1'b0;
      idExNext.setsAllFlags = 1'b0;
      idExNext.setsZero     = 1'b0;
    end
  end

  // Writeback port
  always_ff @(posedge clk) begin
    if (wb.regWe && wb.dst != 4'd0) begin
      regFile[wb.dst] <= wb.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idEx.valid        <= 1'b0;
      idEx.regWe        <= 1'b0;
      idEx.memRe        <= 1'b0;
      idEx.memWe        <= 1'b0;
      idEx.isBranch     <= 1'b0;
      idEx.isHalt       <= 1'b0;
      idEx.setsAllFlags <= 1'b0;
      idEx.setsZero     <= 1'b0;
    end else begin
      idEx <= idExNext;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    (wb.regWe && wb.dst == 4'd0) |-> (wb.data == 16'd0))
    else $error("register 0 written with a nonzero value");

endmodule

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
  input  logic          clk,
  input  logic          rst_n,
  input  cpuPkg::idExT  idEx,
  input  cpuPkg::exMemT exMemFwd,
  input  cpuPkg::memWbT wbFwd,
  output cpuPkg::exMemT exMem,
  output logic          branchTaken,
  output logic [15:0]   branchTarget
);

  logic [15:0] opA;
  logic [15:0] opB;
  logic [15:0] aluOut;
  logic        aluOvf;
  logic        flagZ;
  logic        flagN;
  logic        flagV;
  logic        condMet;

  // Younger stage first; a load in EX/MEM has no data yet
  function automatic logic [15:0] pickOperand(input logic [3:0] src,
                                               input logic [15:0] regVal,
                                               input cpuPkg::exMemT ex,
                                               input cpuPkg::memWbT wb);
    if (ex.valid && ex.regWe && !ex.memRe && ex.dst == src) begin
      return ex.result;
    end else if (wb.regWe && wb.dst == src) begin
      return wb.data;
    end
    return regVal;
  endfunction

  assign opA = pickOperand(idEx.srcA, idEx.opA, exMemFwd, wbFwd);
  assign opB = pickOperand(idEx.srcB, idEx.opB, exMemFwd, wbFwd);

  // ********************************************************************
  // ALU
  // ********************************************************************
  always_comb begin
    aluOvf = 1'b0;
    case (idEx.aluOp)
      cpuPkg::opAdd: begin
        aluOut = opA + opB;
        aluOvf = (opA[15] == opB[15]) && (aluOut[15] != opA[15]);
      end
      cpuPkg::opSub: begin
        aluOut = opA - opB;
        aluOvf = (opA[15] != opB[15]) && (aluOut[15] != opA[15]);
      end
      cpuPkg::opAnd: aluOut = opA & opB;
      cpuPkg::opNor: aluOut = ~(opA | opB);
      cpuPkg::opLlb: aluOut = idEx.imm;
      // Effective address
      cpuPkg::opLw, cpuPkg::opSw: aluOut = opA + idEx.imm;
      default: aluOut = 16'd0;
    endcase
  end

  // Flags update as the instruction leaves EX
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flagZ <= 1'b0;
      flagN <= 1'b0;
      flagV <= 1'b0;
    end else if (idEx.setsAllFlags) begin
      flagZ <= (aluOut == 16'd0);
      flagN <= aluOut[15];
      flagV <= aluOvf;
    end else if (idEx.setsZero) begin
      flagZ <= (aluOut == 16'd0);
    end
  end

  always_comb begin
    case (idEx.cond)
      cpuPkg::condNe: condMet = !flagZ;
      cpuPkg::condEq: condMet = flagZ;
      cpuPkg::condGt: condMet = !flagZ && !flagN;
      cpuPkg::condLt: condMet = flagN;
      cpuPkg::condGe: condMet = flagZ || !flagN;
      cpuPkg::condLe: condMet = flagZ || flagN;
      cpuPkg::condOv: condMet = flagV;
      default:        condMet = 1'b1;
    endcase
  end

  assign branchTaken  = idEx.isBranch && condMet;
  assign branchTarget = idEx.pcPlus1 + idEx.imm;

  // EX/MEM register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exMem.valid  <= 1'b0;
      exMem.regWe  <= 1'b0;
      exMem.memRe  <= 1'b0;
      exMem.memWe  <= 1'b0;
      exMem.isHalt <= 1'b0;
    end else begin
      exMem.result    <= aluOut;
      exMem.storeData <= opB;
      exMem.storeSrc  <= idEx.srcB;
      exMem.dst       <= idEx.dst;
      exMem.regWe     <= idEx.regWe;
      exMem.memRe     <= idEx.memRe;
      exMem.memWe     <= idEx.memWe;
      exMem.isHalt    <= idEx.isHalt;
      exMem.valid     <= idEx.valid;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) branchTaken |-> idEx.valid)
    else $error("branch taken from an empty ID/EX slot");

endmodule

// ==== hdl/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage #(
  parameter int imemDepth = 256
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         go,
  input  logic         stall,
  input  logic         flush,
  input  logic         halted,
  input  logic         branchTaken,
  input  logic [15:0]  branchTarget,
  input  logic         loadReq,
  input  logic [15:0]  loadAddr,
  input  logic [15:0]  loadInstr,
  output logic         loadAck,
  output logic [15:0]  pc,
  output cpuPkg::ifIdT ifId
);

  localparam int imemAw = $clog2(imemDepth);

  logic [15:0]       imem [imemDepth];
  logic [imemAw-1:0] fetchIdx;
  logic [imemAw-1:0] loadIdx;
  logic              loadWrite;

  assign fetchIdx  = imemAw'(pc % 16'(imemDepth));
  assign loadIdx   = imemAw'(loadAddr % 16'(imemDepth));
  // New request seen while idle
  assign loadWrite = loadReq && !loadAck && !go;

  always_ff @(posedge clk) begin
    if (loadWrite) begin
      imem[loadIdx] <= loadInstr;
    end
  end

  // Four-phase load handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      loadAck <= 1'b0;
    end else if (loadWrite) begin
      loadAck <= 1'b1;
    end else if (!loadReq && loadAck) begin
      loadAck <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= 16'd0;
    end else if (!go) begin
      pc <= 16'd0;
    end else if (halted) begin
      pc <= pc;
    end else if (branchTaken) begin
      pc <= branchTarget;
    end else if (!stall) begin
      pc <= pc + 16'd1;
    end
  end

  // IF/ID register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ifId.valid <= 1'b0;
    end else if (!go || flush) begin
      ifId.valid <= 1'b0;
    end else if (!stall) begin
      ifId.instr   <= imem[fetchIdx];
      ifId.pcPlus1 <= pc + 16'd1;
      ifId.valid   <= 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) go |-> !loadReq)
    else $error("program load requested while running");

endmodule

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
  input  logic         clk,
  input  logic         rst_n,
  input  cpuPkg::idExT idEx,
  input  logic [3:0]   idSrcA,
  input  logic [3:0]   idSrcB,
  input  logic         branchTaken,
  input  logic         hlt,
  output logic         stall,
  output logic         flush,
  output logic         halted
);

  logic haltInEx;
  logic haltSeen;

  // Load-use pair gets one bubble
  assign stall = idEx.valid && idEx.memRe && (idEx.dst != 4'd0) &&
                 ((idEx.dst == idSrcA) || (idEx.dst == idSrcB));

  assign haltInEx = idEx.valid && idEx.isHalt;

  // Squash anything younger than a taken branch or a HLT
  assign flush = branchTaken || haltInEx || halted;

  // Sticky once HLT reaches WB
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      haltSeen <= 1'b0;
    end else if (hlt) begin
      haltSeen <= 1'b1;
    end
  end

  assign halted = hlt || haltSeen;

  assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
    else $error("load-use stall held longer than one cycle");

endmodule

// ==== hdl/memoryStage.sv ====
`timescale 1ns/1ps

module memoryStage #(
  parameter int dmemDepth = 256
) (
  input  logic          clk,
  input  logic          rst_n,
  input  cpuPkg::exMemT exMem,
  output cpuPkg::memWbT memWb
);

  localparam int dmemAw = $clog2(dmemDepth);

  logic [15:0]       dmem [dmemDepth];
  logic [dmemAw-1:0] addr;
  logic [15:0]       storeVal;
  logic [15:0]       loadVal;

  assign addr = dmemAw'(exMem.result % 16'(dmemDepth));

  // Store data from the older write now in MEM/WB
  assign storeVal = (memWb.regWe && memWb.dst == exMem.storeSrc) ? memWb.data
                                                                 : exMem.storeData;
  assign loadVal  = dmem[addr];

  always_ff @(posedge clk) begin
    if (exMem.valid && exMem.memWe) begin
      dmem[addr] <= storeVal;
    end
  end

  // ********************************************************************
  // MEM/WB register
  // ********************************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memWb.regWe  <= 1'b0;
      memWb.isHalt <= 1'b0;
    end else begin
      memWb.data   <= exMem.memRe ? loadVal : exMem.result;
      memWb.dst    <= exMem.dst;
      memWb.regWe  <= exMem.valid && exMem.regWe;
      memWb.isHalt <= exMem.valid && exMem.isHalt;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the cpuTb simulation with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  -f compile.f --top-module cpuTb -Mdir obj_dir

# A failing run ends in $fatal, which gives a nonzero exit status
./obj_dir/VcpuTb

// ==== tests/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

  logic           clk;
  logic           rst_n;
  logic           go;
  logic           loadReq;
  logic [15:0]    loadAddr;
  logic [15:0]    loadInstr;
  logic           loadAck;
  logic           hlt;
  logic [15:0]    pc;
  logic           retireValid;
  cpuPkg::retireT retire;

  // Program words and expected writes in file order
  logic [15:0] progAddr [$];
  logic [15:0] progWord [$];
  logic [15:0] expReg [$];
  logic [15:0] expVal [$];
  // End index of each program at its R line
  int          progEnd [$];
  int          expEnd [$];

  int cycleCount = 0;
  int cycleLimit = 0;

  cpuTop #(
    .imemDepth(256),
    .dmemDepth(256)
  ) u_dut (
    .clk(clk), .rst_n(rst_n), .go(go),
    .loadReq(loadReq), .loadAddr(loadAddr), .loadInstr(loadInstr),
    .loadAck(loadAck), .hlt(hlt), .pc(pc),
    .retireValid(retireValid), .retire(retire)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ********************************************************************
  // Error handling
  // ********************************************************************
  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
                            input string what);
    if (actual !== expected) begin
      failRun($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                        $time, what, actual, expected));
    end
  endtask

  // Cycle budget comes from the program sizes in the data file
  initial begin
    forever begin
      @(posedge clk);
      cycleCount++;
      if (cycleLimit > 0 && cycleCount > cycleLimit) begin
        failRun($sformatf("Timeout: the run went past %0d clock cycles", cycleLimit));
      end
    end
  end

  // ********************************************************************
  // Test data
  // ********************************************************************
  task automatic readTestData();
    int          fd;
    int          ch;
    int          n;
    int          lastEnd;
    logic [7:0]  kind;
    logic [15:0] a;
    logic [15:0] b;
    lastEnd = 0;
    fd = $fopen("tests/testdata.txt", "r");
    if (fd == 0) begin
      failRun("Could not open tests/testdata.txt for reading");
    end else begin
      ch = $fgetc(fd);
      while (ch != -1) begin
        kind = 8'(ch);
        if (kind == "#") begin
          // Comment runs to end of line
          while (ch != -1 && ch != 10) begin
            ch = $fgetc(fd);
          end
        end else if (kind == "P") begin
          n = $fscanf(fd, "%h %h", a, b);
          if (n != 2) begin
            failRun("A program line in tests/testdata.txt is malformed");
          end else begin
            progAddr.push_back(a);
            progWord.push_back(b);
          end
        end else if (kind == "E") begin
          n = $fscanf(fd, "%h %h", a, b);
          if (n != 2) begin
            failRun("An expected-write line in tests/testdata.txt is malformed");
          end else begin
            expReg.push_back(a);
            expVal.push_back(b);
          end
        end else if (kind == "R") begin
          progEnd.push_back(progAddr.size());
          expEnd.push_back(expReg.size());
          cycleLimit += 16 * (progAddr.size() - lastEnd) + 100;
          lastEnd = progAddr.size();
        end
        ch = $fgetc(fd);
      end
      $fclose(fd);
    end
  endtask

  // Four-phase handshake for one instruction word
  task automatic loadWord(input logic [15:0] addr, input logic [15:0] data);
    @(posedge clk);
    #2;
    loadAddr  = addr;
    loadInstr = data;
    loadReq   = 1'b1;
    @(negedge clk);
    while (!loadAck) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    loadReq = 1'b0;
    @(negedge clk);
    while (loadAck) begin
      @(negedge clk);
    end
  endtask

  // ********************************************************************
  // Reset, load, run and check the retire trace of one program
  // ********************************************************************
  task automatic runProgram(input int prog, input int wordFirst, input int wordLast,
                            input int expFirst, input int expLast);
    int idx;
    bit seenHalt;
    @(posedge clk);
    #2;
    rst_n   = 1'b0;
    go      = 1'b0;
    loadReq = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    @(negedge clk);
    checkValue(pc, 16'd0, "pc after reset");
    checkValue({15'd0, hlt}, 16'd0, "hlt after reset");
    checkValue({15'd0, loadAck}, 16'd0, "loadAck after reset");
    checkValue({15'd0, retireValid}, 16'd0, "retireValid after reset");

    for (int i = wordFirst; i < wordLast; i++) begin
      loadWord(progAddr[i], progWord[i]);
    end

    @(posedge clk);
    #2;
    go = 1'b1;

    idx      = expFirst;
    seenHalt = 1'b0;
    while (!seenHalt) begin
      @(negedge clk);
      if (retireValid) begin
        if (idx >= expLast) begin
          failRun($sformatf("Program %0d retired more register writes than expected",
                            prog));
        end else begin
          checkValue({12'd0, retire.regNum}, expReg[idx], "retired register");
          checkValue(retire.value, expVal[idx], "retired value");
          idx++;
        end
      end
      if (hlt) begin
        seenHalt = 1'b1;
      end
    end

    if (idx != expLast) begin
      failRun($sformatf("Program %0d halted with %0d expected writes never retired",
                        prog, expLast - idx));
    end else begin
      // Nothing younger than HLT may retire
      repeat (8) begin
        @(negedge clk);
        if (retireValid) begin
          failRun($sformatf("Program %0d retired an instruction after hlt", prog));
        end
        checkValue({15'd0, hlt}, 16'd1, "hlt after halt");
      end
    end
  endtask

  initial begin
    int wordStart;
    int expStart;
    rst_n     = 1'b0;
    go        = 1'b0;
    loadReq   = 1'b0;
    loadAddr  = 16'd0;
    loadInstr = 16'd0;
    wordStart = 0;
    expStart  = 0;

    readTestData();
    if (progEnd.size() == 0) begin
      failRun("No program found in tests/testdata.txt");
    end else begin
      for (int k = 0; k < progEnd.size(); k++) begin
        runProgram(k, wordStart, progEnd[k], expStart, expEnd[k]);
        wordStart = progEnd[k];
        expStart  = expEnd[k];
      end

      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== tests/testdata.txt ====
# P addr word : program word (hex)    E reg value : expected register write (hex)
# R : reset, load the words above, raise go and check the writes in order
# ALU ops, LLB sign extension, forwarding, SW then LW, load-use, write to r0
P 00 A105
P 01 A2FD
P 02 0312
P 03 1431
P 04 2542
P 05 3650
P 06 9613
P 07 8713
P 08 0877
P 09 0011
P 0A F000
E 1 0005
E 2 FFFD
E 3 0002
E 4 FFFD
E 5 FFFD
E 6 0002
E 7 0002
E 8 0004
R
# Branches under each condition, flushed slots hold LLB r4 r6 r7
P 00 A103
P 01 A203
P 02 1312
P 03 C002
P 04 C202
P 05 A411
P 06 A422
P 07 1501
P 08 C401
P 09 C601
P 0A A633
P 0B C801
P 0C CA01
P 0D A644
P 0E CC01
P 0F CE02
P 10 A755
P 11 A766
P 12 A877
P 13 F000
E 1 0003
E 2 0003
E 3 0000
E 5 FFFD
E 8 0077
R
# Reload: cleared flags, a backward loop, and a word after HLT
P 00 C601
P 01 A103
P 02 A201
P 03 1112
P 04 C1FE
P 05 A9AB
P 06 F000
P 07 A4EE
E 1 0003
E 2 0001
E 1 0002
E 1 0001
E 1 0000
E 9 FFAB
R
